/* rtl/axi_demux_pkg.sv */
// AXI demux tracker shared definitions
`default_nettype none

package axi_demux_pkg;

  // Topology
  localparam int num_subs = 2;
  localparam int sub_w = 1;
  localparam int id_w = 2;
  localparam int num_ids = 2 ** id_w;

  // Depth of the per-ID response tracking FIFO
  localparam int max_outstanding = 4;

  localparam int req_payload_w = 8;
  localparam int resp_payload_w = 8;

  // Tracking FIFO pointer and occupancy widths
  localparam int ptr_w = $clog2(max_outstanding);
  localparam int cnt_w = $clog2(max_outstanding + 1);

  typedef logic [id_w-1:0] axi_id_t;
  typedef logic [sub_w-1:0] sub_sel_t;

  // Request as presented to a subordinate
  typedef struct packed {
    axi_id_t                  id;
    logic [req_payload_w-1:0] payload;
  } req_t;

  // One response beat
  typedef struct packed {
    axi_id_t                   id;
    logic [resp_payload_w-1:0] payload;
    logic                      last;
  } resp_t;

endpackage

`default_nettype wire

/* rtl/axi_demux_tracker.sv */
// AXI request demux and response tracker
`timescale 1ns/1ps
`default_nettype none

module axi_demux_tracker
  import axi_demux_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     rst_n,
  // Request from the manager
  input  logic                                     upstream_axvalid,
  output logic                                     upstream_axready,
  input  axi_id_t                                  upstream_axid,
  input  sub_sel_t                                 upstream_ax_sub_select,
  input  logic [req_payload_w-1:0]                 upstream_ax_payload,
  // Requests to the subordinates
  output logic [num_subs-1:0]                      downstream_axvalid,
  input  logic [num_subs-1:0]                      downstream_axready,
  output axi_id_t [num_subs-1:0]                   downstream_axid,
  output logic [num_subs-1:0][req_payload_w-1:0]   downstream_ax_payload,
  // Responses from the subordinates
  input  logic [num_subs-1:0]                      downstream_xvalid,
  output logic [num_subs-1:0]                      downstream_xready,
  input  axi_id_t [num_subs-1:0]                   downstream_xid,
  input  logic [num_subs-1:0]                      downstream_xlast,
  input  logic [num_subs-1:0][resp_payload_w-1:0]  downstream_x_payload,
  // Response to the manager
  output logic                                     upstream_xvalid,
  input  logic                                     upstream_xready,
  output axi_id_t                                  upstream_xid,
  output logic                                     upstream_xlast,
  output logic [resp_payload_w-1:0]                upstream_x_payload,
  // Write data flow token
  output logic                                     wdata_flow_valid,
  input  logic                                     wdata_flow_ready,
  output sub_sel_t                                 wdata_flow_sub_select
);

  req_t [num_subs-1:0]  ds_req;
  resp_t [num_subs-1:0] ds_resp;

  track_if trk ();

  for (genvar i = 0; i < num_subs; i++) begin : gen_port
    assign downstream_axid[i]       = ds_req[i].id;
    assign downstream_ax_payload[i] = ds_req[i].payload;
    assign ds_resp[i] = '{
      id:      downstream_xid[i],
      payload: downstream_x_payload[i],
      last:    downstream_xlast[i]
    };
  end

  req_router i_req_router (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .upstream_axvalid       (upstream_axvalid),
    .upstream_axready       (upstream_axready),
    .upstream_axid          (upstream_axid),
    .upstream_ax_sub_select (upstream_ax_sub_select),
    .upstream_ax_payload    (upstream_ax_payload),
    .downstream_axvalid     (downstream_axvalid),
    .downstream_axready     (downstream_axready),
    .downstream_ax          (ds_req),
    .wdata_flow_valid       (wdata_flow_valid),
    .wdata_flow_ready       (wdata_flow_ready),
    .wdata_flow_sub_select  (wdata_flow_sub_select),
    .trk                    (trk.router)
  );

  resp_track_fifo i_resp_track_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .trk   (trk.fifo)
  );

  resp_arbiter i_resp_arbiter (
    .clk                (clk),
    .rst_n              (rst_n),
    .downstream_xvalid  (downstream_xvalid),
    .downstream_xready  (downstream_xready),
    .downstream_x       (ds_resp),
    .upstream_xvalid    (upstream_xvalid),
    .upstream_xready    (upstream_xready),
    .upstream_xid       (upstream_xid),
    .upstream_xlast     (upstream_xlast),
    .upstream_x_payload (upstream_x_payload),
    .trk                (trk.arbiter)
  );

endmodule

`default_nettype wire

/* rtl/req_router.sv */
// Request skid buffer, fork and demux
`timescale 1ns/1ps
`default_nettype none

module req_router
  import axi_demux_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     upstream_axvalid,
  output logic                     upstream_axready,
  input  axi_id_t                  upstream_axid,
  input  sub_sel_t                 upstream_ax_sub_select,
  input  logic [req_payload_w-1:0] upstream_ax_payload,
  output logic [num_subs-1:0]      downstream_axvalid,
  input  logic [num_subs-1:0]      downstream_axready,
  output req_t [num_subs-1:0]      downstream_ax,
  output logic                     wdata_flow_valid,
  input  logic                     wdata_flow_ready,
  output sub_sel_t                 wdata_flow_sub_select,
  track_if.router                  trk
);

  // Head entry feeds the fork, skid entry catches the beat in flight
  logic     head_valid;
  req_t     head_req;
  sub_sel_t head_sel;
  logic     skid_valid;
  req_t     skid_req;
  sub_sel_t skid_sel;
  logic     in_push;
  logic     head_load;
  logic     head_retire;

  // Branch bits are downstream demux, tracking FIFO and wdata token
  logic [2:0] branch_acc;
  logic [2:0] branch_valid;
  logic [2:0] branch_ready;
  logic [2:0] branch_fire;
  sub_sel_t   demux_sel;
  logic       ds_ready;

  // Ready comes straight from a flop
  assign upstream_axready = ~skid_valid;
  assign in_push          = upstream_axvalid & ~skid_valid;
  assign head_load        = head_retire | ~head_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (head_load) begin
      head_valid <= skid_valid | in_push;
      skid_valid <= 1'b0;
    end else if (in_push) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (head_load) begin
      if (skid_valid) begin
        head_req <= skid_req;
        head_sel <= skid_sel;
      end else begin
        head_req <= '{id: upstream_axid, payload: upstream_ax_payload};
        head_sel <= upstream_ax_sub_select;
      end
    end else if (in_push) begin
      skid_req <= '{id: upstream_axid, payload: upstream_ax_payload};
      skid_sel <= upstream_ax_sub_select;
    end
  end

  // A branch that already took the request stays quiet until it retires
  assign branch_valid = {3{head_valid}} & ~branch_acc;
  assign branch_ready = {wdata_flow_ready, trk.push_ready, ds_ready};
  assign branch_fire  = branch_valid & branch_ready;
  assign head_retire  = head_valid & (&(branch_acc | branch_fire));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      branch_acc <= '0;
    end else if (head_retire) begin
      branch_acc <= '0;
    end else begin
      branch_acc <= branch_acc | branch_fire;
    end
  end

  // Park the select on port 0 when the demux branch is idle
  assign demux_sel = branch_valid[0] ? head_sel : '0;
  assign ds_ready  = downstream_axready[demux_sel];

  for (genvar i = 0; i < num_subs; i++) begin : gen_demux
    assign downstream_axvalid[i] = branch_valid[0] && (demux_sel == sub_sel_t'(i));
    assign downstream_ax[i]      = head_req;
  end

  assign trk.push_valid = branch_valid[1];
  assign trk.push_id    = head_req.id;
  assign trk.push_sub   = head_sel;

  assign wdata_flow_valid      = branch_valid[2];
  assign wdata_flow_sub_select = head_sel;

endmodule

`default_nettype wire

/* rtl/resp_arbiter.sv */
// Response ordering, LRU arbitration and output register
`timescale 1ns/1ps
`default_nettype none

module resp_arbiter
  import axi_demux_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [num_subs-1:0]       downstream_xvalid,
  output logic [num_subs-1:0]       downstream_xready,
  input  resp_t [num_subs-1:0]      downstream_x,
  output logic                      upstream_xvalid,
  input  logic                      upstream_xready,
  output axi_id_t                   upstream_xid,
  output logic                      upstream_xlast,
  output logic [resp_payload_w-1:0] upstream_x_payload,
  track_if.arbiter                  trk
);

  logic [num_subs-1:0] port_req;
  logic [num_subs-1:0] arb_gnt;
  logic [num_subs-1:0] hold_gnt;
  logic [num_subs-1:0] gnt;
  sub_sel_t            gnt_idx;
  sub_sel_t            lru_first;
  sub_sel_t            lru_second;

  logic  pre_valid;
  logic  pre_ready;
  logic  pre_accept;
  resp_t pre_beat;

  logic  out_valid;
  resp_t out_beat;

  // A port may go only when it heads the tracking FIFO of its response ID
  for (genvar i = 0; i < num_subs; i++) begin : gen_req
    assign port_req[i] = downstream_xvalid[i]
                         && trk.pop_valid[downstream_x[i].id]
                         && (trk.pop_sub[downstream_x[i].id] == sub_sel_t'(i));
  end

  // With two ports the LRU order is a single bit naming the older port
  assign lru_second = ~lru_first;

  always_comb begin
    arb_gnt = '0;
    if (port_req[lru_first]) begin
      arb_gnt[lru_first] = 1'b1;
    end else if (port_req[lru_second]) begin
      arb_gnt[lru_second] = 1'b1;
    end
  end

  // Inside a burst the held grant overrides the arbiter
  assign gnt = (|hold_gnt) ? hold_gnt : arb_gnt;

  always_comb begin
    gnt_idx  = '0;
    pre_beat = '0;
    for (int i = 0; i < num_subs; i++) begin
      if (gnt[i]) begin
        gnt_idx  = sub_sel_t'(i);
        pre_beat = pre_beat | downstream_x[i];
      end
    end
  end

  assign pre_valid  = |(port_req & gnt);
  assign pre_ready  = ~out_valid | upstream_xready;
  assign pre_accept = pre_valid & pre_ready;

  assign downstream_xready = gnt & port_req & {num_subs{pre_ready}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_gnt  <= '0;
      lru_first <= '0;
    end else if (pre_accept) begin
      hold_gnt  <= pre_beat.last ? '0 : gnt;
      // The port just served becomes the most recent one
      lru_first <= ~gnt_idx;
    end
  end

  // The last beat of a burst retires the head entry of its ID
  for (genvar j = 0; j < num_ids; j++) begin : gen_pop
    assign trk.pop_ready[j] = pre_accept && pre_beat.last && (pre_beat.id == axi_id_t'(j));
  end

  // Forward register, refilled in the cycle it drains
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (pre_ready) begin
      out_valid <= pre_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pre_accept) begin
      out_beat <= pre_beat;
    end
  end

  assign upstream_xvalid    = out_valid;
  assign upstream_xid       = out_beat.id;
  assign upstream_xlast     = out_beat.last;
  assign upstream_x_payload = out_beat.payload;

endmodule

`default_nettype wire

/* rtl/resp_track_fifo.sv */
// Per-ID response port FIFOs
`timescale 1ns/1ps
`default_nettype none

module resp_track_fifo
  import axi_demux_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  track_if.fifo  trk
);

  logic [num_ids-1:0] id_full;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] nxt;
    if (ptr == ptr_w'(max_outstanding - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // A full FIFO for the incoming ID stalls the fork
  assign trk.push_ready = ~id_full[trk.push_id];

  for (genvar i = 0; i < num_ids; i++) begin : gen_id
    sub_sel_t         mem [max_outstanding];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             push_en;
    logic             pop_en;

    assign push_en = trk.push_valid && trk.push_ready && (trk.push_id == axi_id_t'(i));
    assign pop_en  = trk.pop_ready[i] && (count != '0);

    assign id_full[i]       = (count == cnt_w'(max_outstanding));
    assign trk.pop_valid[i] = (count != '0);
    assign trk.pop_sub[i]   = mem[rd_ptr];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
      end else begin
        if (push_en) begin
          wr_ptr <= next_ptr(wr_ptr);
        end
        if (pop_en) begin
          rd_ptr <= next_ptr(rd_ptr);
        end
        count <= count + cnt_w'(push_en) - cnt_w'(pop_en);
      end
    end

    always_ff @(posedge clk) begin
      if (push_en) begin
        mem[wr_ptr] <= trk.push_sub;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/track_if.sv */
// Response tracking FIFO link
`timescale 1ns/1ps
`default_nettype none

interface track_if
  import axi_demux_pkg::*;
();

  // Push side, one entry per routed request
  logic     push_valid;
  logic     push_ready;
  axi_id_t  push_id;
  sub_sel_t push_sub;

  // Pop side, the head of each per-ID FIFO
  logic [num_ids-1:0]     pop_valid;
  sub_sel_t [num_ids-1:0] pop_sub;
  logic [num_ids-1:0]     pop_ready;

  modport router (output push_valid, output push_id, output push_sub, input push_ready);

  modport fifo (
    input  push_valid, push_id, push_sub, pop_ready,
    output push_ready, pop_valid, pop_sub
  );

  modport arbiter (input pop_valid, input pop_sub, output pop_ready);

endinterface

`default_nettype wire

/* sim.f */
rtl/axi_demux_pkg.sv
rtl/track_if.sv
rtl/req_router.sv
rtl/resp_track_fifo.sv
rtl/resp_arbiter.sv
rtl/axi_demux_tracker.sv
verif/axi_demux_properties.sv
verif/tb_axi_demux_tracker.sv

/* verif/axi_demux_properties.sv */
// Handshake assertions for the demux tracker
`timescale 1ns/1ps
`default_nettype none

module axi_demux_properties
  import axi_demux_pkg::*;
(
  input logic                                   clk,
  input logic                                   rst_n,
  input logic [num_subs-1:0]                    downstream_axvalid,
  input logic [num_subs-1:0]                    downstream_axready,
  input axi_id_t [num_subs-1:0]                 downstream_axid,
  input logic [num_subs-1:0][req_payload_w-1:0] downstream_ax_payload,
  input logic [num_subs-1:0]                    downstream_xready,
  input logic [num_subs-1:0]                    downstream_xlast,
  input logic                                   upstream_xvalid,
  input logic                                   upstream_xready,
  input axi_id_t                                upstream_xid,
  input logic                                   upstream_xlast,
  input logic [resp_payload_w-1:0]              upstream_x_payload
);

  int       fail_count = 0;
  logic     in_burst;
  sub_sel_t burst_port;

  // Port of the response burst in progress, taken from the accepted beats
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_burst <= 1'b0;
    end else if (|downstream_xready) begin
      in_burst   <= ~downstream_xlast[downstream_xready[1]];
      burst_port <= downstream_xready[1];
    end
  end

  a_up_stable: assert property (@(posedge clk) disable iff (!rst_n)
    upstream_xvalid && !upstream_xready |=>
      upstream_xvalid && $stable({upstream_xid, upstream_xlast, upstream_x_payload}))
  else begin
    $error("Upstream response changed before it was taken");
    fail_count++;
  end

  // A stalled request keeps its port, ID and payload until that port takes it
  a_ax_hold: assert property (@(posedge clk) disable iff (!rst_n)
    |(downstream_axvalid & ~downstream_axready) |=>
      $onehot0(downstream_axvalid) && downstream_axvalid == $past(downstream_axvalid)
      && $stable({downstream_axid, downstream_ax_payload}))
  else begin
    $error("Downstream request changed before it was taken");
    fail_count++;
  end

  // No beat from the other port until the burst ends
  a_no_interleave: assert property (@(posedge clk) disable iff (!rst_n)
    in_burst |-> !downstream_xready[~burst_port])
  else begin
    $error("Response burst interleaved with another port");
    fail_count++;
  end

endmodule

bind axi_demux_tracker axi_demux_properties i_props (.*);

`default_nettype wire

/* verif/tb_axi_demux_tracker.sv */
// AXI demux tracker directed testbench
`timescale 1ns/1ps
`default_nettype none

module tb_axi_demux_tracker;
  import axi_demux_pkg::*;

  localparam int clk_period = 100;
  localparam int num_reqs = 24;
  localparam int timeout_cycles = num_reqs * 40 + 2;

  logic                                    clk;
  logic                                    rst_n;
  logic                                    upstream_axvalid;
  logic                                    upstream_axready;
  axi_id_t                                 upstream_axid;
  sub_sel_t                                upstream_ax_sub_select;
  logic [req_payload_w-1:0]                upstream_ax_payload;
  logic [num_subs-1:0]                     downstream_axvalid;
  logic [num_subs-1:0]                     downstream_axready;
  axi_id_t [num_subs-1:0]                  downstream_axid;
  logic [num_subs-1:0][req_payload_w-1:0]  downstream_ax_payload;
  logic [num_subs-1:0]                     downstream_xvalid;
  logic [num_subs-1:0]                     downstream_xready;
  axi_id_t [num_subs-1:0]                  downstream_xid;
  logic [num_subs-1:0]                     downstream_xlast;
  logic [num_subs-1:0][resp_payload_w-1:0] downstream_x_payload;
  logic                                    upstream_xvalid;
  logic                                    upstream_xready;
  axi_id_t                                 upstream_xid;
  logic                                    upstream_xlast;
  logic [resp_payload_w-1:0]               upstream_x_payload;
  logic                                    wdata_flow_valid;
  logic                                    wdata_flow_ready;
  sub_sel_t                                wdata_flow_sub_select;

  int       errors = 0;
  int       seed = 51;
  int       acc_cnt = 0;
  // Observed traffic, and what the subordinates still owe a response for
  req_t     sub_q[num_subs][$];
  req_t     pend_q[num_subs][$];
  req_t     exp_q[num_subs][$];
  sub_sel_t tok_q[$];
  sub_sel_t exp_tok[$];
  resp_t    up_q[$];

  axi_demux_tracker i_dut (.*);

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  // Handshakes are sampled mid-cycle, where every signal has settled
  always @(negedge clk) begin
    if (rst_n) begin
      for (int s = 0; s < num_subs; s++) begin
        if (downstream_axvalid[s] && downstream_axready[s]) begin
          sub_q[s].push_back(req_t'{id: downstream_axid[s], payload: downstream_ax_payload[s]});
          pend_q[s].push_back(req_t'{id: downstream_axid[s], payload: downstream_ax_payload[s]});
        end
      end
      if (wdata_flow_valid && wdata_flow_ready) begin
        tok_q.push_back(wdata_flow_sub_select);
      end
      if (upstream_xvalid && upstream_xready) begin
        up_q.push_back(resp_t'{id: upstream_xid, payload: upstream_x_payload,
                               last: upstream_xlast});
      end
      if (upstream_axvalid && upstream_axready) begin
        acc_cnt++;
      end
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // Sends one request and records where it has to show up
  task automatic issue(input axi_id_t id, input sub_sel_t sel, input logic [7:0] pl);
    exp_q[sel].push_back(req_t'{id: id, payload: pl});
    exp_tok.push_back(sel);
    upstream_axvalid       = 1'b1;
    upstream_axid          = id;
    upstream_ax_sub_select = sel;
    upstream_ax_payload    = pl;
    @(negedge clk);
    while (!upstream_axready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #10;
    upstream_axvalid = 1'b0;
  endtask

  task automatic send_burst(input int s, input axi_id_t id, input int beats,
                            input logic [7:0] base);
    for (int k = 0; k < beats; k++) begin
      downstream_xvalid[s]    = 1'b1;
      downstream_xid[s]       = id;
      downstream_xlast[s]     = (k == beats - 1);
      downstream_x_payload[s] = base + 8'(k);
      @(negedge clk);
      while (!downstream_xready[s]) begin
        @(negedge clk);
      end
      @(posedge clk);
      #10;
    end
    downstream_xvalid[s] = 1'b0;
  endtask

  task automatic wait_beats(input int n);
    while (up_q.size() < n) begin
      @(negedge clk);
    end
    @(posedge clk);
    #10;
  endtask

  // Compares every routed request and token with the recorded ones
  task automatic verify_routing(input string name);
    req_t got;
    while (tok_q.size() < exp_tok.size()) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    for (int s = 0; s < num_subs; s++) begin
      check({name, " count"}, exp_q[s].size(), sub_q[s].size());
      while (exp_q[s].size() > 0 && sub_q[s].size() > 0) begin
        got = sub_q[s].pop_front();
        check(name, exp_q[s].pop_front(), got);
      end
      exp_q[s].delete();
      sub_q[s].delete();
    end
    check({name, " tokens"}, exp_tok.size(), tok_q.size());
    while (exp_tok.size() > 0 && tok_q.size() > 0) begin
      check({name, " token"}, exp_tok.pop_front(), tok_q.pop_front());
    end
    exp_tok.delete();
    tok_q.delete();
    @(posedge clk);
    #10;
  endtask

  task automatic respond_all(input int s);
    while (pend_q[s].size() > 0) begin
      send_burst(s, pend_q[s][0].id, 1, 8'h00);
      void'(pend_q[s].pop_front());
    end
  endtask

  // Both subordinates answer in parallel so the oldest request can always go
  task automatic drain();
    int total;
    total = pend_q[0].size() + pend_q[1].size();
    fork
      respond_all(0);
      respond_all(1);
    join
    wait_beats(total);
    up_q.delete();
  endtask

  task automatic clear_pending();
    pend_q[0].delete();
    pend_q[1].delete();
    up_q.delete();
  endtask

  task automatic route_requests();
    fork
      for (int k = 0; k < 8; k++) begin
        issue(axi_id_t'(k), sub_sel_t'($random(seed)), 8'($random(seed)));
      end
      begin
        // Both subordinates stall for a while so a request backs up in the fork
        repeat (3) @(posedge clk);
        #10;
        downstream_axready = '0;
        repeat (5) @(posedge clk);
        #10;
        downstream_axready = '1;
      end
    join
    verify_routing("routing");
    drain();
  endtask

  task automatic stall_token();
    int base;
    base = acc_cnt;
    wdata_flow_ready = 1'b0;
    fork
      for (int k = 0; k < 4; k++) begin
        issue(axi_id_t'(k), sub_sel_t'($random(seed)), 8'($random(seed)));
      end
      begin
        repeat (10) @(posedge clk);
        // Head and skid entry are the only requests taken
        check("token_stall accepted", 2, acc_cnt - base);
        #10;
        wdata_flow_ready = 1'b1;
      end
    join
    verify_routing("token_stall");
    drain();
  endtask

  task automatic order_same_id();
    issue(2'd1, 1'b1, 8'h11);
    issue(2'd1, 1'b0, 8'h22);
    verify_routing("same_id route");
    fork
      send_burst(0, 2'd1, 1, 8'ha0);
      begin
        repeat (3) @(posedge clk);
        #10;
        send_burst(1, 2'd1, 1, 8'hb0);
      end
    join
    wait_beats(2);
    check("same_id first", 8'hb0, up_q[0].payload);
    check("same_id second", 8'ha0, up_q[1].payload);
    clear_pending();
  endtask

  task automatic interleave_ids();
    issue(2'd2, 1'b0, 8'h33);
    issue(2'd3, 1'b1, 8'h44);
    verify_routing("diff_id route");
    send_burst(1, 2'd3, 1, 8'hc0);
    wait_beats(1);
    check("diff_id first", 3, up_q[0].id);
    send_burst(0, 2'd2, 1, 8'hd0);
    wait_beats(2);
    check("diff_id second", 2, up_q[1].id);
    check("diff_id payload", 8'hd0, up_q[1].payload);
    clear_pending();
  endtask

  task automatic merge_bursts();
    logic [7:0] first;
    issue(2'd0, 1'b0, 8'h55);
    issue(2'd2, 1'b1, 8'h66);
    verify_routing("bursts route");
    fork
      send_burst(0, 2'd0, 3, 8'h40);
      send_burst(1, 2'd2, 3, 8'h50);
      begin
        // The manager stalls once the first beat is out
        while (up_q.size() < 1) begin
          @(negedge clk);
        end
        @(posedge clk);
        #10;
        upstream_xready = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        upstream_xready = 1'b1;
      end
    join
    wait_beats(6);
    // Port 0 answered last in the previous test, so port 1 is older and wins
    first = 8'h50;
    for (int k = 0; k < 6; k++) begin
      check("bursts payload", (k < 3 ? first : first ^ 8'h10) + k % 3, up_q[k].payload);
      check("bursts last", k % 3 == 2, up_q[k].last);
    end
    clear_pending();
  endtask

  task automatic fill_tracker();
    int held;
    for (int k = 0; k < 4; k++) begin
      issue(2'd3, sub_sel_t'(k), 8'h70 + 8'(k));
    end
    // The fifth stalls the fork and the sixth waits behind it
    issue(2'd3, 1'b1, 8'h74);
    issue(2'd0, 1'b0, 8'h75);
    repeat (10) @(posedge clk);
    held = 0;
    for (int s = 0; s < num_subs; s++) begin
      for (int i = 0; i < sub_q[s].size(); i++) begin
        held += (sub_q[s][i].id == 2'd0);
      end
    end
    check("tracker_full held", 0, held);
    check("tracker_full tokens", 5, tok_q.size());
    #10;
    send_burst(0, 2'd3, 1, 8'h80);
    verify_routing("tracker_full");
    void'(pend_q[0].pop_front());
    wait_beats(1);
    up_q.delete();
    drain();
  endtask

  initial begin
    rst_n                  = 1'b0;
    upstream_axvalid       = 1'b0;
    upstream_axid          = '0;
    upstream_ax_sub_select = '0;
    upstream_ax_payload    = '0;
    downstream_axready     = '1;
    downstream_xvalid      = '0;
    downstream_xid         = '0;
    downstream_xlast       = '0;
    downstream_x_payload   = '0;
    upstream_xready        = 1'b1;
    wdata_flow_ready       = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
    route_requests();
    stall_token();
    order_same_id();
    interleave_ids();
    merge_bursts();
    fill_tracker();
    $display("Errors: %0d check mismatches, %0d assertion failures",
             errors, i_dut.i_props.fail_count);
    if (errors == 0 && i_dut.i_props.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
